// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -j 0
TOP       = silver_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/silver_alu.sv ====
module silver_alu import silver_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      flag_en,
   input  alu_func_e func,
   input  word_t     a,
   input  word_t     b,
   output word_t     result
);

   logic                  carry, overflow;
   logic                  carry_in;
   logic [WORD_W:0]       sum;
   word_t                 diff;
   logic [2*WORD_W-1:0]   product;
   logic                  add_ovf, sub_ovf;

   assign carry_in = (func == fAddWithCarry) && carry;
   assign sum      = {1'b0, a} + {1'b0, b} + {{WORD_W{1'b0}}, carry_in};
   assign diff     = a - b;
   assign product  = {{WORD_W{1'b0}}, a} * {{WORD_W{1'b0}}, b};

   assign add_ovf = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
   assign sub_ovf = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);

   always_comb begin
      case (func)
         fAdd, fAddWithCarry: result = sum[WORD_W-1:0];
         fSub:      result = diff;
         fCarry:    result = word_t'(carry);
         fOverflow: result = word_t'(overflow);
         fInc:      result = a + word_t'(1);
         fDec:      result = a - word_t'(1);
         fMul:      result = product[WORD_W-1:0];
         fMulHU:    result = product[2*WORD_W-1:WORD_W];   // high word, unsigned
         fAnd:      result = a & b;
         fOr:       result = a | b;
         fXor:      result = a ^ b;
         fEqual:    result = word_t'(a == b);
         fLess:     result = word_t'($signed(a) < $signed(b));
         fLower:    result = word_t'(a < b);
         default:   result = b;   // fSnd
      endcase
   end

   // flags change only for instructions that really use the ALU
   always_ff @(posedge clk) begin
      if (rst) begin
         carry    <= 1'b0;
         overflow <= 1'b0;
      end else if (flag_en) begin
         if (func == fAdd || func == fAddWithCarry)
            carry <= sum[WORD_W];
         if (func == fAdd)
            overflow <= add_ovf;
         else if (func == fSub)
            overflow <= sub_ovf;
      end
   end

   a_func_known: assert property (@(posedge clk) disable iff (rst)
      flag_en |-> !$isunknown(func));

endmodule

// ==== source/silver_core.sv ====
module silver_core import silver_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  word_t     instr,
   input  in_data_t  data_in,
   output word_t     pc,
   output out_data_t data_out,
   output logic      out_valid
);

   // fetch to decode
   word_t     fd_instr, fd_pc;

   // decode outputs
   opcode_e   id_opc;
   alu_func_e id_func;
   reg_addr_t id_addr_a, id_addr_b, id_addr_w;
   word_t     id_opnd_a, id_opnd_b, id_opnd_w, id_imm;
   logic      id_reads_a, id_reads_b, id_reads_w, id_writes;
   word_t     rf_a, rf_b, rf_w;

   // decode to execute
   opcode_e   de_opc;
   alu_func_e de_func;
   word_t     de_pc, de_opnd_a, de_opnd_b, de_opnd_w, de_imm;
   reg_addr_t de_addr_a, de_addr_b, de_addr_w;
   logic      de_reads_a, de_reads_b, de_reads_w, de_writes;

   word_t     ex_result, jump_target;
   logic      jump_taken;

   // execute to memory, memory to writeback
   logic      em_wr, em_out;
   reg_addr_t em_addr;
   word_t     em_result;
   logic      mw_wr, mw_out;
   reg_addr_t mw_addr;
   word_t     mw_result;

   always_ff @(posedge clk) begin
      if (rst)
         pc <= RESET_PC;
      else if (jump_taken)
         pc <= jump_target;
      else
         pc <= pc + PC_STEP;
   end

   always_ff @(posedge clk) begin
      if (rst || jump_taken)
         fd_instr <= NOP_INSTR;   // flushed slot
      else
         fd_instr <= instr;
      fd_pc <= pc;
   end

   silver_decode decode_i (
      .instr      (fd_instr),
      .reg_a      (rf_a),
      .reg_b      (rf_b),
      .reg_w      (rf_w),
      .opc        (id_opc),
      .func       (id_func),
      .addr_a     (id_addr_a),
      .addr_b     (id_addr_b),
      .addr_w     (id_addr_w),
      .opnd_a     (id_opnd_a),
      .opnd_b     (id_opnd_b),
      .opnd_w     (id_opnd_w),
      .imm        (id_imm),
      .reads_a    (id_reads_a),
      .reads_b    (id_reads_b),
      .reads_w    (id_reads_w),
      .writes_reg (id_writes)
   );

   silver_regfile regfile_i (
      .clk     (clk),
      .rst     (rst),
      .addr_a  (id_addr_a),
      .addr_b  (id_addr_b),
      .addr_w  (id_addr_w),
      .wr_addr (mw_addr),
      .wr_en   (mw_wr),
      .wr_data (mw_result),
      .data_a  (rf_a),
      .data_b  (rf_b),
      .data_w  (rf_w)
   );

   always_ff @(posedge clk) begin
      if (rst || jump_taken) begin
         de_opc    <= OPC_BUBBLE;
         de_writes <= 1'b0;
      end else begin
         de_opc    <= id_opc;
         de_writes <= id_writes;
      end
      de_func    <= id_func;
      de_pc      <= fd_pc;
      de_opnd_a  <= id_opnd_a;
      de_opnd_b  <= id_opnd_b;
      de_opnd_w  <= id_opnd_w;
      de_imm     <= id_imm;
      de_addr_a  <= id_addr_a;
      de_addr_b  <= id_addr_b;
      de_addr_w  <= id_addr_w;
      de_reads_a <= id_reads_a;
      de_reads_b <= id_reads_b;
      de_reads_w <= id_reads_w;
   end

   silver_execute execute_i (
      .clk         (clk),
      .rst         (rst),
      .opc         (de_opc),
      .func        (de_func),
      .pc          (de_pc),
      .opnd_a      (de_opnd_a),
      .opnd_b      (de_opnd_b),
      .opnd_w      (de_opnd_w),
      .imm         (de_imm),
      .addr_a      (de_addr_a),
      .addr_b      (de_addr_b),
      .addr_w      (de_addr_w),
      .reads_a     (de_reads_a),
      .reads_b     (de_reads_b),
      .reads_w     (de_reads_w),
      .mem_wr      (em_wr),
      .mem_addr    (em_addr),
      .mem_result  (em_result),
      .wb_wr       (mw_wr),
      .wb_addr     (mw_addr),
      .wb_result   (mw_result),
      .data_in     (data_in),
      .result      (ex_result),
      .jump_target (jump_target),
      .jump_taken  (jump_taken)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         em_wr  <= 1'b0;
         em_out <= 1'b0;
         mw_wr  <= 1'b0;
         mw_out <= 1'b0;
      end else begin
         em_wr  <= de_writes;
         em_out <= (de_opc == OPC_OUT);
         mw_wr  <= em_wr;    // memory stage just passes through
         mw_out <= em_out;
      end
      em_addr   <= de_addr_w;
      em_result <= ex_result;
      mw_addr   <= em_addr;
      mw_result <= em_result;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         data_out  <= '0;
         out_valid <= 1'b0;
      end else begin
         out_valid <= mw_out;
         if (mw_out)
            data_out <= mw_result[OUT_W-1:0];
      end
   end

   a_no_out_in_reset: assert property (@(posedge clk) rst |=> !out_valid);

   a_pc_step: assert property (@(posedge clk) disable iff (rst)
      !jump_taken |=> pc == $past(pc) + PC_STEP);

endmodule

// ==== source/silver_decode.sv ====
module silver_decode import silver_pkg::*; (
   input  word_t      instr,
   input  word_t      reg_a,
   input  word_t      reg_b,
   input  word_t      reg_w,
   output opcode_e    opc,
   output alu_func_e  func,
   output reg_addr_t  addr_a,
   output reg_addr_t  addr_b,
   output reg_addr_t  addr_w,
   output word_t      opnd_a,
   output word_t      opnd_b,
   output word_t      opnd_w,
   output word_t      imm,
   output logic       reads_a,
   output logic       reads_b,
   output logic       reads_w,
   output logic       writes_reg
);

   logic imm_a, imm_b, imm_w;   // operand immediate flags

   assign imm_a = instr[23];
   assign imm_b = instr[16];
   assign imm_w = instr[31];

   assign addr_a = instr[22:17];
   assign addr_b = instr[15:10];
   assign addr_w = instr[30:25];

   // classify by bit 24, bit 31 and the low six bits
   always_comb begin
      opc = OPC_BUBBLE;
      if (instr[24]) begin
         if (instr[31])
            opc = OPC_LOAD_CONST;
         else if (instr[23:9] == '0)
            opc = OPC_LOAD_UPPER;
      end else begin
         case (instr[5:0])
            6'd0:  opc = imm_w ? OPC_BUBBLE : OPC_NORMAL;
            6'd1:  opc = imm_w ? OPC_BUBBLE : OPC_SHIFT;
            6'd6:  opc = imm_w ? OPC_BUBBLE : OPC_OUT;
            6'd7:  opc = imm_w ? OPC_BUBBLE : OPC_IN;
            6'd9:  opc = imm_w ? OPC_BUBBLE : OPC_JUMP;
            6'd10: opc = OPC_JUMP_Z;    // W may be immediate here
            6'd11: opc = OPC_JUMP_NZ;
            default: opc = OPC_BUBBLE;  // memory, accelerator, interrupt
         endcase
      end
   end

   always_comb begin
      case (opc)
         OPC_NORMAL, OPC_SHIFT, OPC_OUT, OPC_JUMP, OPC_JUMP_Z, OPC_JUMP_NZ:
            func = alu_func_e'(instr[9:6]);
         default:
            func = DEFAULT_FUNC;
      endcase
   end

   assign opnd_a = imm_a ? word_t'($signed(instr[22:17])) : reg_a;
   assign opnd_b = imm_b ? word_t'($signed(instr[15:10])) : reg_b;
   assign opnd_w = imm_w ? word_t'($signed(instr[30:25])) : reg_w;

   always_comb begin
      imm = '0;
      if (opc == OPC_LOAD_CONST)
         imm = instr[23] ? word_t'(0) - word_t'(instr[22:0]) : word_t'(instr[22:0]);
      else if (opc == OPC_LOAD_UPPER)
         imm = word_t'(instr[8:0]);    // placed above the low 23 bits in execute
   end

   // only real register reads get forwarded
   assign reads_a = !imm_a && (opc inside {OPC_NORMAL, OPC_SHIFT, OPC_OUT, OPC_JUMP,
                                           OPC_JUMP_Z, OPC_JUMP_NZ});
   assign reads_b = !imm_b && (opc inside {OPC_NORMAL, OPC_SHIFT, OPC_OUT,
                                           OPC_JUMP_Z, OPC_JUMP_NZ});
   assign reads_w = !imm_w && (opc inside {OPC_JUMP_Z, OPC_JUMP_NZ, OPC_LOAD_UPPER});

   assign writes_reg = opc inside {OPC_NORMAL, OPC_SHIFT, OPC_OUT, OPC_IN, OPC_JUMP,
                                   OPC_LOAD_CONST, OPC_LOAD_UPPER};

endmodule

// ==== source/silver_execute.sv ====
module silver_execute import silver_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  opcode_e   opc,
   input  alu_func_e func,
   input  word_t     pc,
   input  word_t     opnd_a,
   input  word_t     opnd_b,
   input  word_t     opnd_w,
   input  word_t     imm,
   input  reg_addr_t addr_a,
   input  reg_addr_t addr_b,
   input  reg_addr_t addr_w,
   input  logic      reads_a,
   input  logic      reads_b,
   input  logic      reads_w,
   input  logic      mem_wr,
   input  reg_addr_t mem_addr,
   input  word_t     mem_result,
   input  logic      wb_wr,
   input  reg_addr_t wb_addr,
   input  word_t     wb_result,
   input  in_data_t  data_in,
   output word_t     result,
   output word_t     jump_target,
   output logic      jump_taken
);

   word_t     fa, fb, fw;       // forwarded operands
   word_t     alu_a, alu_b, alu_res;
   word_t     shift_res;
   logic [4:0] rot_amt;
   logic      flag_en;

   // newest producer first
   function automatic word_t forward(input logic rd, input reg_addr_t addr,
                                     input word_t value, input logic m_wr,
                                     input reg_addr_t m_addr, input word_t m_res,
                                     input logic w_wr, input reg_addr_t w_addr,
                                     input word_t w_res);
      word_t v;
      v = value;
      if (rd && m_wr && m_addr == addr)
         v = m_res;
      else if (rd && w_wr && w_addr == addr)
         v = w_res;
      return v;
   endfunction

   assign fa = forward(reads_a, addr_a, opnd_a, mem_wr, mem_addr, mem_result,
                       wb_wr, wb_addr, wb_result);
   assign fb = forward(reads_b, addr_b, opnd_b, mem_wr, mem_addr, mem_result,
                       wb_wr, wb_addr, wb_result);
   assign fw = forward(reads_w, addr_w, opnd_w, mem_wr, mem_addr, mem_result,
                       wb_wr, wb_addr, wb_result);

   assign alu_a = (opc == OPC_JUMP) ? pc : fa;
   assign alu_b = (opc == OPC_JUMP) ? fa : fb;

   assign flag_en = opc inside {OPC_NORMAL, OPC_OUT, OPC_JUMP, OPC_JUMP_Z, OPC_JUMP_NZ};

   silver_alu alu_i (
      .clk     (clk),
      .rst     (rst),
      .flag_en (flag_en),
      .func    (func),
      .a       (alu_a),
      .b       (alu_b),
      .result  (alu_res)
   );

   assign rot_amt = fb[4:0];

   always_comb begin
      case (func[1:0])
         2'd0:    shift_res = fa << fb;
         2'd1:    shift_res = fa >> fb;
         2'd2:    shift_res = word_t'($signed(fa) >>> fb);
         default: shift_res = (fa >> rot_amt) | (fa << (WORD_W - rot_amt));  // rotate
      endcase
   end

   always_comb begin
      case (opc)
         OPC_JUMP:       result = pc + PC_STEP;   // link value
         OPC_LOAD_CONST: result = imm;
         OPC_LOAD_UPPER: result = {imm[8:0], fw[22:0]};
         OPC_IN:         result = {{(WORD_W-IN_W){1'b0}}, data_in};
         OPC_SHIFT:      result = shift_res;
         default:        result = alu_res;
      endcase
   end

   always_comb begin
      jump_taken  = 1'b0;
      jump_target = pc + fw;
      case (opc)
         OPC_JUMP: begin
            jump_taken  = 1'b1;
            jump_target = alu_res;
         end
         OPC_JUMP_Z:  jump_taken = (alu_res == '0);
         OPC_JUMP_NZ: jump_taken = (alu_res != '0);
         default:     jump_taken = 1'b0;
      endcase
   end

endmodule

// ==== source/silver_pkg.sv ====
package silver_pkg;

   localparam int WORD_W     = 32;
   localparam int REG_ADDR_W = 6;
   localparam int NUM_REGS   = 64;
   localparam int OUT_W      = 10;   // output port
   localparam int IN_W       = 2;    // input port

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [OUT_W-1:0]      out_data_t;
   typedef logic [IN_W-1:0]       in_data_t;

   // values follow the low six instruction bits where they exist
   typedef enum logic [3:0] {
      OPC_NORMAL     = 4'd0,
      OPC_SHIFT      = 4'd1,
      OPC_OUT        = 4'd6,
      OPC_IN         = 4'd7,
      OPC_JUMP       = 4'd9,
      OPC_JUMP_Z     = 4'd10,
      OPC_JUMP_NZ    = 4'd11,
      OPC_LOAD_CONST = 4'd13,
      OPC_LOAD_UPPER = 4'd14,
      OPC_BUBBLE     = 4'd15
   } opcode_e;

   typedef enum logic [3:0] {
      fAdd,
      fAddWithCarry,
      fSub,
      fCarry,
      fOverflow,
      fInc,
      fDec,
      fMul,
      fMulHU,
      fAnd,
      fOr,
      fXor,
      fEqual,
      fLess,
      fLower,
      fSnd
   } alu_func_e;

   localparam alu_func_e DEFAULT_FUNC = fAnd;

   localparam word_t PC_STEP  = 32'd4;
   localparam word_t RESET_PC = 32'd0;

   // low six bits 63 never decode to a kept opcode
   localparam word_t NOP_INSTR = 32'h0000_003f;

endpackage

// ==== source/silver_regfile.sv ====
module silver_regfile import silver_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  reg_addr_t addr_a,
   input  reg_addr_t addr_b,
   input  reg_addr_t addr_w,
   input  reg_addr_t wr_addr,
   input  logic      wr_en,
   input  word_t     wr_data,
   output word_t     data_a,
   output word_t     data_b,
   output word_t     data_w
);

   word_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // writeback in the same cycle wins
   assign data_a = (wr_en && addr_a == wr_addr) ? wr_data : regs[addr_a];
   assign data_b = (wr_en && addr_b == wr_addr) ? wr_data : regs[addr_b];
   assign data_w = (wr_en && addr_w == wr_addr) ? wr_data : regs[addr_w];

   a_wr_addr_known: assert property (@(posedge clk) disable iff (rst)
      wr_en |-> !$isunknown(wr_addr));

endmodule

// ==== tb.f ====
+incdir+tests
source/silver_pkg.sv
source/silver_decode.sv
source/silver_regfile.sv
source/silver_alu.sv
source/silver_execute.sv
source/silver_core.sv
tests/silver_tb.sv

// ==== tests/silver_model.svh ====
// sequential reference state
word_t m_regs [NUM_REGS];
logic  m_carry;
logic  m_ovf;

function automatic word_t sext6(input logic [5:0] v);
   return {{(WORD_W-6){v[5]}}, v};
endfunction

// one ALU operation, flags read before they change
task automatic alu_op(input alu_func_e f, input word_t a, input word_t b,
                      output word_t res);
   logic [WORD_W:0]        s;
   logic [2*WORD_W-1:0]    p;
   logic signed [WORD_W:0] s_add;
   logic signed [WORD_W:0] s_sub;
   logic                   cin;
   cin   = (f == fAddWithCarry) && m_carry;
   s     = {1'b0, a} + {1'b0, b} + {{WORD_W{1'b0}}, cin};
   p     = {{WORD_W{1'b0}}, a} * {{WORD_W{1'b0}}, b};
   s_add = $signed({a[WORD_W-1], a}) + $signed({b[WORD_W-1], b});
   s_sub = $signed({a[WORD_W-1], a}) - $signed({b[WORD_W-1], b});
   case (f)
      fAdd, fAddWithCarry: res = s[WORD_W-1:0];
      fSub:      res = a - b;
      fCarry:    res = {{(WORD_W-1){1'b0}}, m_carry};
      fOverflow: res = {{(WORD_W-1){1'b0}}, m_ovf};
      fInc:      res = a + 32'd1;
      fDec:      res = a - 32'd1;
      fMul:      res = p[WORD_W-1:0];
      fMulHU:    res = p[2*WORD_W-1:WORD_W];
      fAnd:      res = a & b;
      fOr:       res = a | b;
      fXor:      res = a ^ b;
      fEqual:    res = {{(WORD_W-1){1'b0}}, a == b};
      fLess:     res = {{(WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
      fLower:    res = {{(WORD_W-1){1'b0}}, a < b};
      default:   res = b;
   endcase
   if (f == fAdd || f == fAddWithCarry)
      m_carry = s[WORD_W];
   if (f == fAdd)
      m_ovf = s_add[WORD_W] != s_add[WORD_W-1];   // result left the signed range
   else if (f == fSub)
      m_ovf = s_sub[WORD_W] != s_sub[WORD_W-1];
endtask

function automatic word_t shift_op(input logic [1:0] kind, input word_t a, input word_t amt);
   int n;
   n = (amt > 32'd31) ? 32 : int'(amt);
   case (kind)
      2'd0:    return (n == 32) ? '0 : a << n;
      2'd1:    return (n == 32) ? '0 : a >> n;
      2'd2:    return (n == 32) ? {WORD_W{a[WORD_W-1]}} : word_t'($signed(a) >>> n);
      default: return word_t'({a, a} >> amt[4:0]);   // rotate, amount mod 32
   endcase
endfunction

// runs prog up to the final self loop, fills exp_out
task automatic run_model();
   int         idx, cyc, nxt;
   word_t      ins, a, b, w, pc, res;
   logic [5:0] wa;
   logic       taken;
   for (int i = 0; i < NUM_REGS; i++)
      m_regs[i] = '0;
   m_carry = 1'b0;
   m_ovf   = 1'b0;
   exp_out.delete();
   idx = 0;
   cyc = 0;   // fetch cycle of the current instruction
   while (idx != PROG_LEN - 1) begin
      ins   = prog[idx];
      pc    = word_t'(idx) * PC_STEP;
      wa    = ins[30:25];
      a     = ins[23] ? sext6(ins[22:17]) : m_regs[ins[22:17]];
      b     = ins[16] ? sext6(ins[15:10]) : m_regs[ins[15:10]];
      w     = ins[31] ? sext6(ins[30:25]) : m_regs[wa];
      nxt   = idx + 1;
      taken = 1'b0;
      if (ins[24]) begin
         if (ins[31])
            m_regs[wa] = ins[23] ? -word_t'(ins[22:0]) : word_t'(ins[22:0]);
         else
            m_regs[wa] = {ins[8:0], w[22:0]};   // load upper
      end else begin
         case (ins[5:0])
            6'd0, 6'd6: begin
               alu_op(alu_func_e'(ins[9:6]), a, b, res);
               m_regs[wa] = res;
               if (ins[5:0] == 6'd6)
                  exp_out.push_back(res[OUT_W-1:0]);
            end
            6'd1: m_regs[wa] = shift_op(ins[7:6], a, b);
            6'd7: m_regs[wa] = word_t'(din[(cyc + 2) % DIN_LEN]);   // value in execute
            6'd9: begin
               alu_op(alu_func_e'(ins[9:6]), pc, a, res);
               m_regs[wa] = pc + PC_STEP;
               taken = 1'b1;
               nxt = int'(res >> 2);
            end
            default: begin
               alu_op(alu_func_e'(ins[9:6]), a, b, res);
               taken = (ins[5:0] == 6'd10) == (res == '0);
               if (taken)
                  nxt = int'((pc + w) >> 2);
            end
         endcase
      end
      cyc += taken ? 3 : 1;   // two flushed fetches after a taken jump
      idx = nxt;
   end
endtask

// ==== tests/silver_tb.sv ====
module silver_tb import silver_pkg::*; ();

   localparam int    NUM_PROGS      = 12;
   localparam int    PROG_LEN       = 48;
   localparam int    DIN_LEN        = 256;
   localparam int    TIMEOUT_CYCLES = NUM_PROGS * (PROG_LEN * 3 + 30);
   localparam word_t FINAL_PC       = word_t'(PROG_LEN - 1) * PC_STEP;

   logic      clk = 1'b0;
   logic      rst;
   word_t     instr;
   in_data_t  data_in;
   word_t     pc;
   out_data_t data_out;
   logic      out_valid;

   int        seed = 97;
   word_t     prog [PROG_LEN];
   in_data_t  din [DIN_LEN];   // data_in per cycle after reset
   out_data_t exp_out [$];
   int        n_out;
   int        err_value = 0;
   int        err_other = 0;
   int        cycles = 0;

   `include "silver_model.svh"

   always #20 clk = ~clk;

   // instruction memory, answers in the same cycle
   assign instr = (pc <= FINAL_PC) ? prog[pc[7:2]] : NOP_INSTR;

   silver_core silver_core_i (
      .clk       (clk),
      .rst       (rst),
      .instr     (instr),
      .data_in   (data_in),
      .pc        (pc),
      .data_out  (data_out),
      .out_valid (out_valid)
   );

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic word_t encode(input logic [5:0] opc, input logic [3:0] fn,
                                    input logic iw, input logic [5:0] w,
                                    input logic ia, input logic [5:0] a,
                                    input logic ib, input logic [5:0] b);
      return {iw, w, 1'b0, ia, a, ib, b, fn, opc};
   endfunction

   // immediate or one of the first eight registers, so hazards are frequent
   function automatic logic [5:0] pick_src(input logic is_imm);
      return is_imm ? 6'(rand_below(64)) : 6'(rand_below(8));
   endfunction

   function automatic int jump_dist(input int i);
      int k;
      k = 1 + int'(rand_below(7));
      if (i + k > PROG_LEN - 1)
         k = PROG_LEN - 1 - i;   // never past the final loop
      return k;
   endfunction

   task automatic gen_program();
      logic [5:0] w;
      logic       ia, ib;
      for (int i = 0; i < PROG_LEN - 1; i++) begin
         w  = 6'(rand_below(8));
         ia = rand_below(4) == 0;
         ib = rand_below(4) == 0;
         case (rand_below(16))
            0, 1, 2, 3: prog[i] = encode(6'd0, 4'(rand_below(16)), 1'b0, w,
                                         ia, pick_src(ia), ib, pick_src(ib));
            4, 5:       prog[i] = encode(6'd1, 4'(rand_below(4)), 1'b0, w,
                                         ia, pick_src(ia), ib, pick_src(ib));
            6, 7, 8, 9: prog[i] = encode(6'd6, 4'(rand_below(16)), 1'b0, w,
                                         ia, pick_src(ia), ib, pick_src(ib));
            10:         prog[i] = encode(6'd7, 4'd0, 1'b0, w, 1'b0, 6'd0, 1'b0, 6'd0);
            11: prog[i] = {1'b1, w, 1'b1, rand_below(2) == 0,
                           rand_below(2) == 0 ? 23'(rand_below(64)) : 23'(rand_below(1 << 23))};
            12: prog[i] = {1'b0, w, 1'b1, 15'd0, 9'(rand_below(512))};
            13: prog[i] = encode(6'd9, 4'(fAdd), 1'b0, w, 1'b1, 6'(4 * jump_dist(i)),
                                 1'b0, 6'd0);
            default: prog[i] = encode(rand_below(2) == 0 ? 6'd10 : 6'd11,
                                      4'(rand_below(16)), 1'b1, 6'(4 * jump_dist(i)),
                                      ia, pick_src(ia), ib, pick_src(ib));
         endcase
      end
      prog[PROG_LEN-1] = encode(6'd9, 4'(fAdd), 1'b0, 6'(rand_below(8)), 1'b1, 6'd0,
                                1'b0, 6'd0);   // jump to itself
      for (int j = 0; j < DIN_LEN; j++)
         din[j] = in_data_t'(rand_below(4));
   endtask

   task automatic check_out(input out_data_t got);
      if (n_out >= exp_out.size()) begin
         err_other++;
         $display("unexpected Out result %h at time %0t, model has only %0d",
                  got, $time, exp_out.size());
      end else if (got !== exp_out[n_out]) begin
         err_value++;
         $display("** Error at time %0t: data_out = %h, expected %h",
                  $time, got, exp_out[n_out]);
      end
      n_out++;
   endtask

   task automatic check_count(input int got);
      if (got != exp_out.size()) begin
         err_value++;
         $display("** Error at time %0t: out_valid count = %0d, expected %0d",
                  $time, got, exp_out.size());
      end
   endtask

   task automatic run_program();
      int k;
      int hold;
      rst     = 1'b1;
      data_in = in_data_t'(rand_below(4));
      repeat (2) begin
         @(negedge clk);
         if (out_valid) begin
            err_other++;
            $display("out_valid set during reset at time %0t", $time);
         end
      end
      rst     = 1'b0;
      k       = 0;
      hold    = 0;
      n_out   = 0;
      data_in = din[0];
      while (hold < 8) begin   // until the final loop address is seen 8 times
         @(negedge clk);
         if (out_valid)
            check_out(data_out);
         if (pc == FINAL_PC)
            hold++;
         k++;
         data_in = din[k % DIN_LEN];
      end
      check_count(n_out);
   endtask

   initial begin
      rst     = 1'b1;
      data_in = '0;
      for (int p = 0; p < NUM_PROGS; p++) begin
         gen_program();
         run_model();
         run_program();
      end
      $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
      if (err_value == 0 && err_other == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the core never reached its final loop", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

endmodule
